//--- logic/snac_mode_pkg.sv
/*
 * Pad selection definitions: type codes, poll rates and strobe step width.
 * Imported by the mode control, strobe generator, reader and pin map.
 */
`default_nettype none

package snac_mode_pkg;

    // Pad type codes as written by the host
    // Codes not listed here leave the reader idle
    typedef enum logic [4:0] {
        PAD_DISABLED  = 5'd0,
        PAD_DB15      = 5'd1,
        PAD_NES       = 5'd2,
        PAD_SNES      = 5'd3,
        PAD_DB15_FAST = 5'd9
    } pad_type_e;

    // Phase accumulator width of the strobe generator
    localparam int unsigned STEP_W = 32;

    // Poll rates in Hz
    // NES and SNES share the slow rate, pads with slow shift registers
    localparam int unsigned POLL_SNES_HZ      = 50_000;
    localparam int unsigned POLL_DB15_HZ      = 200_000;
    localparam int unsigned POLL_DB15_FAST_HZ = 400_000;

    // Step size rule
    // The strobe runs at twice the poll rate, one strobe per clock phase
    // Step = 2^STEP_W * 2 * rate / clock frequency, fixed at elaboration
    // A step of 0 stops the strobe

endpackage

`default_nettype wire

//--- logic/snac_bus_pkg.sv
/*
 * Serial-latch wire protocol definitions: button word, reader states, bit counts.
 */
`default_nettype none

package snac_bus_pkg;

    // Bit i is the i-th bit shifted out by the pad, 1 when pressed
    typedef logic [15:0] btn_t;

    // Reader FSM, each state lasts one strobe
    typedef enum logic [2:0] {
        S_IDLE,
        S_LATCH_HI,
        S_LATCH_LO,
        S_CLK_LO,
        S_CLK_HI
    } sl_state_e;

    // Bits read per frame
    localparam int unsigned BITS_NES  = 8;
    localparam int unsigned BITS_SNES = 16;
    localparam int unsigned BITS_DB15 = 12;

    localparam int unsigned BIT_CNT_W = 5;

endpackage

`default_nettype wire

//--- logic/snac_mode_ctrl.sv
/*
 * Registers the selected pad type and pulses a restart when it changes.
 * Selects the strobe step for the registered type.
 */
`timescale 1ns/1ps
`default_nettype none

module snac_mode_ctrl
    import snac_mode_pkg::*;
#(
    parameter int unsigned CLK_FREQ_HZ = 25_000_000
) (
    input  wire                i_clk,
    input  wire                i_rst_n,
    input  wire pad_type_e     i_pad_type,
    output pad_type_e          o_pad_type,
    output logic [STEP_W-1:0]  o_step,
    output logic               o_restart
);

    // Step for a given poll rate, strobe at twice the rate
    // 64-bit math so that 2^33 * rate does not overflow
    function automatic logic [STEP_W-1:0] step_for(input longint unsigned rate_hz);
        longint unsigned full;
        full = ((64'd1 << STEP_W) * 64'd2 * rate_hz) / CLK_FREQ_HZ;
        return full[STEP_W-1:0];
    endfunction

    localparam logic [STEP_W-1:0] STEP_SNES      = step_for(POLL_SNES_HZ);
    localparam logic [STEP_W-1:0] STEP_DB15      = step_for(POLL_DB15_HZ);
    localparam logic [STEP_W-1:0] STEP_DB15_FAST = step_for(POLL_DB15_FAST_HZ);

    // Registered copy of the selection
    // Restart fires in the same cycle the new copy appears
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pad_type <= PAD_DISABLED;
            o_restart  <= 1'b0;
        end else begin
            o_pad_type <= i_pad_type;
            o_restart  <= (i_pad_type != o_pad_type);
        end
    end

    // Step follows the registered type, so it lines up with restart
    always_comb begin
        case (o_pad_type)
            PAD_NES, PAD_SNES: o_step = STEP_SNES;
            PAD_DB15:          o_step = STEP_DB15;
            PAD_DB15_FAST:     o_step = STEP_DB15_FAST;
            // Disabled and unsupported codes stop the strobe
            default:           o_step = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/frac_strobe_gen.sv
/*
 * Fractional-rate strobe from a phase accumulator.
 * Average rate is step / 2^STEP_W strobes per clock; a step of 0 stops it.
 */
`timescale 1ns/1ps
`default_nettype none

module frac_strobe_gen
    import snac_mode_pkg::*;
(
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  wire               i_restart,
    input  wire [STEP_W-1:0]  i_step,
    output logic              o_stb
);

    // Next phase is one bit wider so the top bit is the carry-out
    logic [STEP_W:0]   sum;
    logic [STEP_W-1:0] phase;

    assign sum = {1'b0, phase} + {1'b0, i_step};

    // One-cycle pulse on each wrap of the phase
    assign o_stb = sum[STEP_W];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase <= '0;
        end else if (i_restart) begin
            // New rate starts from phase 0
            phase <= '0;
        end else begin
            phase <= sum[STEP_W-1:0];
        end
    end

    // Steps below half the range give strobes that are one-cycle pulses
    a_stb_one_cycle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_stb && !i_step[STEP_W-1]) ##1 !i_step[STEP_W-1] |-> !o_stb
    );

endmodule

`default_nettype wire

//--- logic/serlatch_reader.sv
/*
 * Latch/clock reader for two serial-latch pads sharing clock and latch.
 * Shifts inverted data into shadow words and publishes both at frame end.
 */
`timescale 1ns/1ps
`default_nettype none

module serlatch_reader
    import snac_mode_pkg::*, snac_bus_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    input  wire             i_restart,
    input  wire             i_stb,
    input  wire pad_type_e  i_pad_type,
    input  wire             i_dat1,
    input  wire             i_dat2,
    output logic            o_pad_clk,
    output logic            o_latch,
    output logic            o_busy,
    output btn_t            o_p1_btn,
    output btn_t            o_p2_btn
);

    sl_state_e             state;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [BIT_CNT_W-1:0]  frame_bits;
    logic                  last_bit;
    btn_t                  shadow1;
    btn_t                  shadow2;

    // Bits per frame, 0 keeps the FSM in idle
    always_comb begin
        case (i_pad_type)
            PAD_NES:                 frame_bits = BIT_CNT_W'(BITS_NES);
            PAD_SNES:                frame_bits = BIT_CNT_W'(BITS_SNES);
            PAD_DB15, PAD_DB15_FAST: frame_bits = BIT_CNT_W'(BITS_DB15);
            default:                 frame_bits = '0;
        endcase
    end

    assign last_bit = (bit_cnt == frame_bits - 1'b1);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= S_IDLE;
            bit_cnt   <= '0;
            o_latch   <= 1'b0;
            o_pad_clk <= 1'b0;
            o_busy    <= 1'b0;
            o_p1_btn  <= '0;
            o_p2_btn  <= '0;
        end else if (i_restart) begin
            // Type change, abandon any frame in progress
            state     <= S_IDLE;
            bit_cnt   <= '0;
            o_latch   <= 1'b0;
            o_pad_clk <= 1'b0;
            o_busy    <= 1'b0;
            o_p1_btn  <= '0;
            o_p2_btn  <= '0;
        end else if (i_stb) begin
            case (state)
                S_IDLE: begin
                    if (frame_bits != '0) begin
                        state   <= S_LATCH_HI;
                        o_latch <= 1'b1;
                        o_busy  <= 1'b1;
                        bit_cnt <= '0;
                    end
                end
                S_LATCH_HI: begin
                    // Pads now present bit 0
                    state   <= S_LATCH_LO;
                    o_latch <= 1'b0;
                end
                S_LATCH_LO: state <= S_CLK_LO;
                S_CLK_LO: begin
                    // Rising edge shifts the pad after this sample
                    state     <= S_CLK_HI;
                    o_pad_clk <= 1'b1;
                end
                S_CLK_HI: begin
                    o_pad_clk <= 1'b0;
                    if (last_bit) begin
                        state    <= S_IDLE;
                        o_busy   <= 1'b0;
                        o_p1_btn <= shadow1;
                        o_p2_btn <= shadow2;
                    end else begin
                        state   <= S_CLK_LO;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Shadow words, cleared at frame start so unread bits stay 0
    // Pads pull data low for a pressed button
    always_ff @(posedge i_clk) begin
        if (i_stb && state == S_IDLE) begin
            shadow1 <= '0;
            shadow2 <= '0;
        end else if (i_stb && state == S_CLK_LO) begin
            shadow1[bit_cnt[3:0]] <= ~i_dat1;
            shadow2[bit_cnt[3:0]] <= ~i_dat2;
        end
    end

    a_latch_clk_excl: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(o_latch && o_pad_clk)
    );

    a_idle_not_busy: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (state == S_IDLE) |-> !o_busy
    );

endmodule

`default_nettype wire

//--- logic/snac_port_map.sv
/*
 * Cartridge pin map, configuration A, one register stage each way.
 * Fixed pin directions, player-2 clock on pin30, DB15 alternate data on pin31.
 */
`timescale 1ns/1ps
`default_nettype none

module snac_port_map
    import snac_mode_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    input  wire pad_type_e  i_pad_type,
    input  wire             i_pad_clk,
    input  wire             i_latch,
    // Bank0 bits 7:4, only bits 5:4 carry pad data here
    input  wire [3:0]       i_cart_bk0_in,
    input  wire             i_cart_pin31_in,
    output logic            o_cart_bk0_dir,
    output logic [1:0]      o_cart_bk1_out,
    output logic            o_cart_pin30_out,
    output logic            o_cart_pin30_dir,
    output logic            o_cart_pin31_dir,
    output logic            o_dat1,
    output logic            o_dat2
);

    logic is_db15;
    logic p2_clk_en;

    // DB15 crossed cables may return player-1 data on pin31
    assign is_db15   = (i_pad_type == PAD_DB15) || (i_pad_type == PAD_DB15_FAST);
    // Separate player-2 clock only on NES/SNES cables
    assign p2_clk_en = (i_pad_type == PAD_NES) || (i_pad_type == PAD_SNES);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cart_bk0_dir   <= 1'b0;
            o_cart_pin30_dir <= 1'b1;
            o_cart_pin31_dir <= 1'b0;
            o_cart_bk1_out   <= 2'b00;
            o_cart_pin30_out <= 1'b0;
            // Idle data high, nothing pressed
            o_dat1           <= 1'b1;
            o_dat2           <= 1'b1;
        end else begin
            // Bank0 and pin31 in, pin30 out
            o_cart_bk0_dir   <= 1'b0;
            o_cart_pin30_dir <= 1'b1;
            o_cart_pin31_dir <= 1'b0;
            // Bank1 bit 7 latch, bit 6 pad clock
            o_cart_bk1_out   <= {i_latch, i_pad_clk};
            o_cart_pin30_out <= i_pad_clk & p2_clk_en;
            // Low on either line reads as pressed
            o_dat1 <= is_db15 ? (i_cart_bk0_in[0] & i_cart_pin31_in) : i_cart_bk0_in[0];
            o_dat2 <= i_cart_bk0_in[1];
        end
    end

endmodule

`default_nettype wire

//--- logic/snac_top.sv
/*
 * Two-player serial-latch pad reader for the cartridge-port adapter.
 * Set CLK_FREQ_HZ to the core clock; select the pad with i_pad_type.
 */
`timescale 1ns/1ps
`default_nettype none

module snac_top
    import snac_mode_pkg::*, snac_bus_pkg::*;
#(
    parameter int unsigned CLK_FREQ_HZ = 25_000_000
) (
    input  wire             i_clk,
    input  wire             i_rst_n,
    input  wire pad_type_e  i_pad_type,
    input  wire [3:0]       i_cart_bk0_in,
    // Pin30 is driven in this pin map, input present for the full pinout
    input  wire             i_cart_pin30_in,
    input  wire             i_cart_pin31_in,
    output wire btn_t       o_p1_btn,
    output wire btn_t       o_p2_btn,
    output wire             o_busy,
    output wire             o_cart_bk0_dir,
    output wire [1:0]       o_cart_bk1_out,
    output wire             o_cart_pin30_out,
    output wire             o_cart_pin30_dir,
    output wire             o_cart_pin31_dir
);

    wire pad_type_e    pad_type;
    wire [STEP_W-1:0]  step;
    wire               restart;
    wire               stb;
    wire               pad_clk;
    wire               latch;
    wire               dat1;
    wire               dat2;

    snac_mode_ctrl #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ)
    ) u_mode_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_pad_type (i_pad_type),
        .o_pad_type (pad_type),
        .o_step     (step),
        .o_restart  (restart)
    );

    frac_strobe_gen u_strobe (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_restart (restart),
        .i_step    (step),
        .o_stb     (stb)
    );

    serlatch_reader u_reader (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_restart  (restart),
        .i_stb      (stb),
        .i_pad_type (pad_type),
        .i_dat1     (dat1),
        .i_dat2     (dat2),
        .o_pad_clk  (pad_clk),
        .o_latch    (latch),
        .o_busy     (o_busy),
        .o_p1_btn   (o_p1_btn),
        .o_p2_btn   (o_p2_btn)
    );

    snac_port_map u_port_map (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_pad_type       (pad_type),
        .i_pad_clk        (pad_clk),
        .i_latch          (latch),
        .i_cart_bk0_in    (i_cart_bk0_in),
        .i_cart_pin31_in  (i_cart_pin31_in),
        .o_cart_bk0_dir   (o_cart_bk0_dir),
        .o_cart_bk1_out   (o_cart_bk1_out),
        .o_cart_pin30_out (o_cart_pin30_out),
        .o_cart_pin30_dir (o_cart_pin30_dir),
        .o_cart_pin31_dir (o_cart_pin31_dir),
        .o_dat1           (dat1),
        .o_dat2           (dat2)
    );

endmodule

`default_nettype wire

//--- testbench/tb_pad_model.sv
/*
 * Behavioral model of two serial-latch pads on the cartridge port.
 * Latch loads the raw words, each rising pad clock shifts one bit out.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_pad_model (
    input  wire        i_latch,
    input  wire        i_clk1,
    input  wire        i_clk2,
    input  wire [15:0] i_word1,
    input  wire [15:0] i_word2,
    input  wire        i_alt_low,
    output wire        o_dat1,
    output wire        o_dat2,
    output wire        o_alt
);

    // Pad shift registers, idle high means nothing pressed
    logic [15:0] sr1 = 16'hFFFF;
    logic [15:0] sr2 = 16'hFFFF;

    // Player 1 shifts on the shared pad clock
    // Latch and clock are never high together
    always @(posedge i_latch or posedge i_clk1) begin
        if (i_latch) begin
            sr1 <= i_word1;
        end else begin
            // Ones past the end of the word
            sr1 <= {1'b1, sr1[15:1]};
        end
    end

    // Player 2 shifts on the pin30 clock copy
    always @(posedge i_latch or posedge i_clk2) begin
        if (i_latch) begin
            sr2 <= i_word2;
        end else begin
            sr2 <= {1'b1, sr2[15:1]};
        end
    end

    assign o_dat1 = sr1[0];
    assign o_dat2 = sr2[0];

    // Crossed DB15 cable, second copy of player-1 data
    assign o_alt  = i_alt_low ? 1'b0 : sr1[0];

endmodule

`default_nettype wire

//--- testbench/tb_snac_top.sv
/*
 * Directed testbench for snac_top with two behavioral serial-latch pads.
 * Runs reset, NES, SNES, DB15, DB15 fast and idle-code tests in sequence.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_snac_top
    import snac_mode_pkg::*, snac_bus_pkg::*;
();

    localparam int CLK_NS      = 40;
    // About 4 SNES frames per test, 34 strobes of 250 cycles each
    localparam int NUM_TESTS   = 6;
    localparam int WATCHDOG_NS = NUM_TESTS * 34 * 250 * CLK_NS * 4;

    logic        clk;
    logic        rst_n;
    pad_type_e   pad_type;
    logic [3:0]  bk0_in;
    logic        pin30_in;
    logic        pin31_in;
    wire btn_t   p1_btn;
    wire btn_t   p2_btn;
    wire         busy;
    wire         bk0_dir;
    wire [1:0]   bk1_out;
    wire         pin30_out;
    wire         pin30_dir;
    wire         pin31_dir;

    // Pad model side
    logic [15:0] word1;
    logic [15:0] word2;
    logic        alt_low;
    wire         pad_dat1;
    wire         pad_dat2;
    wire         pad_alt;

    logic [15:0] lfsr_state;
    string       test_name;

    snac_top #(
        .CLK_FREQ_HZ (25_000_000)
    ) u_dut (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_pad_type       (pad_type),
        .i_cart_bk0_in    (bk0_in),
        .i_cart_pin30_in  (pin30_in),
        .i_cart_pin31_in  (pin31_in),
        .o_p1_btn         (p1_btn),
        .o_p2_btn         (p2_btn),
        .o_busy           (busy),
        .o_cart_bk0_dir   (bk0_dir),
        .o_cart_bk1_out   (bk1_out),
        .o_cart_pin30_out (pin30_out),
        .o_cart_pin30_dir (pin30_dir),
        .o_cart_pin31_dir (pin31_dir)
    );

    // Bank1 bit 7 is the latch, bit 6 the pad clock
    tb_pad_model u_pads (
        .i_latch   (bk1_out[1]),
        .i_clk1    (bk1_out[0]),
        .i_clk2    (pin30_out),
        .i_word1   (word1),
        .i_word2   (word2),
        .i_alt_low (alt_low),
        .o_dat1    (pad_dat1),
        .o_dat2    (pad_dat2),
        .o_alt     (pad_alt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Pad lines reach the DUT on the falling edge
    always @(negedge clk) begin
        bk0_in   <= {2'b11, pad_dat2, pad_dat1};
        pin31_in <= pad_alt;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_btn(input string what, input btn_t exp, input btn_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s %s: expected %h, actual %h",
                                test_name, what, exp, act));
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s %s: expected %b, actual %b",
                                test_name, what, exp, act));
        end
    endtask

    task automatic check_type(input string what, input pad_type_e exp, input pad_type_e act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s %s: expected %0d, actual %0d",
                                test_name, what, exp, act));
        end
    endtask

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit of the word
    task automatic rand_word(output logic [15:0] w);
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[i] = lfsr_state[0];
        end
    endtask

    // Registered type shows up one cycle after the change
    task automatic set_type(input pad_type_e t);
        @(negedge clk);
        pad_type = t;
        @(negedge clk);
        check_type("registered type", t, u_dut.pad_type);
    endtask

    // Counts falling edges of busy, optionally watching pin30 stay low
    task automatic wait_frames(input int n, input logic p2_clk_quiet);
        int   falls;
        logic prev;
        falls = 0;
        prev  = busy;
        while (falls < n) begin
            @(negedge clk);
            if (p2_clk_quiet) begin
                check_bit("pin30 clock", 1'b0, pin30_out);
            end
            if (prev && !busy) begin
                falls++;
            end
            prev = busy;
        end
    endtask

    // Reader frozen, outputs cleared, latch and clock pins quiet
    task automatic hold_idle(input int cycles);
        repeat (2) @(negedge clk);
        repeat (cycles) begin
            @(negedge clk);
            check_btn("player 1", 16'h0000, p1_btn);
            check_btn("player 2", 16'h0000, p2_btn);
            check_bit("busy", 1'b0, busy);
            check_bit("latch pin", 1'b0, bk1_out[1]);
            check_bit("clock pin", 1'b0, bk1_out[0]);
        end
    endtask

    task automatic test_reset();
        test_name = "reset";
        check_type("registered type", PAD_DISABLED, u_dut.pad_type);
        check_btn("player 1", 16'h0000, p1_btn);
        check_btn("player 2", 16'h0000, p2_btn);
        check_bit("busy", 1'b0, busy);
        check_bit("latch pin", 1'b0, bk1_out[1]);
        check_bit("clock pin", 1'b0, bk1_out[0]);
        check_bit("pin30 out", 1'b0, pin30_out);
        check_bit("bank0 dir", 1'b0, bk0_dir);
        check_bit("pin31 dir", 1'b0, pin31_dir);
        check_bit("pin30 dir", 1'b1, pin30_dir);
    endtask

    task automatic test_nes();
        test_name = "nes";
        rand_word(word1);
        rand_word(word2);
        set_type(PAD_NES);
        wait_frames(2, 1'b0);
        // Only 8 bits read, upper byte stays clear
        check_btn("player 1", {8'h00, ~word1[7:0]}, p1_btn);
        check_btn("player 2", {8'h00, ~word2[7:0]}, p2_btn);
    endtask

    task automatic test_snes();
        test_name = "snes";
        rand_word(word1);
        rand_word(word2);
        set_type(PAD_SNES);
        wait_frames(2, 1'b0);
        check_btn("player 1", ~word1, p1_btn);
        check_btn("player 2", ~word2, p2_btn);
    endtask

    task automatic test_db15(input pad_type_e t, input string name);
        test_name = name;
        alt_low = 1'b0;
        rand_word(word1);
        rand_word(word2);
        set_type(t);
        wait_frames(2, 1'b1);
        check_btn("player 1", {4'h0, ~word1[11:0]}, p1_btn);
        // Alternate line held low wins the AND, every button pressed
        alt_low = 1'b1;
        wait_frames(2, 1'b1);
        check_btn("player 1 alt low", 16'h0FFF, p1_btn);
        alt_low = 1'b0;
    endtask

    task automatic test_idle_codes();
        test_name = "idle codes";
        rand_word(word1);
        rand_word(word2);
        set_type(PAD_SNES);
        wait_frames(2, 1'b0);
        check_btn("player 1", ~word1, p1_btn);
        // Code 4 belongs to a dropped reader
        set_type(pad_type_e'(5'd4));
        hold_idle(1000);
        set_type(PAD_SNES);
        wait_frames(2, 1'b0);
        check_btn("player 2", ~word2, p2_btn);
        set_type(PAD_DISABLED);
        hold_idle(1000);
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("Timeout: run did not finish within %0d ns", WATCHDOG_NS));
    end

    initial begin
        rst_n      = 1'b0;
        pad_type   = PAD_DISABLED;
        bk0_in     = 4'hF;
        pin30_in   = 1'b0;
        pin31_in   = 1'b1;
        word1      = 16'hFFFF;
        word2      = 16'hFFFF;
        alt_low    = 1'b0;
        lfsr_state = 16'd79;
        test_name  = "init";
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_reset();
        test_nes();
        test_snes();
        test_db15(PAD_DB15, "db15");
        test_db15(PAD_DB15_FAST, "db15 fast");
        test_idle_codes();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
logic/snac_mode_pkg.sv
logic/snac_bus_pkg.sv
logic/snac_mode_ctrl.sv
logic/frac_strobe_gen.sv
logic/serlatch_reader.sv
logic/snac_port_map.sv
logic/snac_top.sv
testbench/tb_pad_model.sv
testbench/tb_snac_top.sv
